// File: hdl/router_cfg_pkg.sv
/* Port configuration of the ingress register block: port count, counter width,
   MTU and block identity */

package router_cfg_pkg;

    ////////////////////////////////////////
    // Port configuration
    ////////////////////////////////////////

    // Number of ingress ports served by the block
    localparam int NUM_PORTS = 4;

    // Counter width, also the register word width
    localparam int CNT_W = 32;

    // Largest packet size in bytes
    localparam int MTU_BYTES = 5000;

    ////////////////////////////////////////
    // Block identity
    ////////////////////////////////////////

    // Major in the upper byte, minor in the lower
    localparam logic [15:0] MODULE_VERSION = 16'h0100;
    localparam logic [15:0] MODULE_ID      = 16'd10;

endpackage

// File: hdl/router_regmap_pkg.sv
/* Register map of the ingress register block: word addresses, snapshot layout,
   map size and constant register contents */

package router_regmap_pkg;

    // Word address width on the access channel
    localparam int ADDR_W = 8;

    ////////////////////////////////////////
    // Word addresses
    ////////////////////////////////////////

    localparam int ADDR_VERSION_ID       = 0;
    localparam int ADDR_PORTS_PARAM      = 1;
    localparam int ADDR_MTU_PARAM        = 2;
    localparam int ADDR_PORT_ENABLE_CON  = 3;
    localparam int ADDR_PORT_ENABLE_STAT = 4;
    localparam int ADDR_COUNTER_CON      = 5;
    // First snapshot word of port 0
    localparam int ADDR_COUNTERS_START   = 6;

    ////////////////////////////////////////
    // Snapshot group of one port
    ////////////////////////////////////////

    localparam int CNTRS_PER_PORT = 4;
    localparam int IDX_PKT        = 0;
    localparam int IDX_BYTE       = 1;
    localparam int IDX_ERR        = 2;
    localparam int IDX_DROP       = 3;

    // Everything at or above this address is unmapped
    localparam int TOTAL_REGS = ADDR_COUNTERS_START + router_cfg_pkg::NUM_PORTS * CNTRS_PER_PORT;

    // Version in the upper half, ID in the lower half
    localparam logic [router_cfg_pkg::CNT_W-1:0] VERSION_ID_VAL = {
        router_cfg_pkg::MODULE_VERSION,
        router_cfg_pkg::MODULE_ID
    };

endpackage

// File: hdl/reg_access_ctrl.sv
/* Access controller: request handshake, address range check,
   port-enable and counter-control registers, enable status */

module reg_access_ctrl (
    input  logic                                   core_clk_ifc,
    input  logic                                   peripheral_sresetn_core,

    // Request channel
    input  logic                                   req_valid,
    output logic                                   req_ready,
    input  logic                                   req_write,
    input  logic [router_regmap_pkg::ADDR_W-1:0]   req_addr,
    input  logic [router_cfg_pkg::CNT_W-1:0]       req_wdata,

    // Response slot state from the read path
    input  logic                                   rsp_slot_free,

    // Accepted access towards the read path
    output logic                                   acc_valid,
    output logic [router_regmap_pkg::ADDR_W-1:0]   acc_addr,
    output logic                                   acc_error,

    // Control and status registers
    output logic [router_cfg_pkg::NUM_PORTS-1:0]   enable_con,
    output logic [router_cfg_pkg::NUM_PORTS-1:0]   enable_stat,
    output logic [router_cfg_pkg::NUM_PORTS-1:0]   counter_con
);

    logic req_fire;
    logic wr_fire;
    logic addr_bad;

    // The access stage and the response slot advance together
    assign req_ready = rsp_slot_free;
    assign req_fire  = req_valid && req_ready;
    assign wr_fire   = req_fire && req_write;
    assign addr_bad  = req_addr >= router_regmap_pkg::TOTAL_REGS;

    ////////////////////////////////////////
    // Access stage
    ////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            acc_valid <= 1'b0;
        end else if (rsp_slot_free) begin
            acc_valid <= req_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (req_fire) begin
            // Writes carry no read data, so point them at an unmapped word
            acc_addr  <= req_write ? '1 : req_addr;
            acc_error <= addr_bad;
        end
    end

    ////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////

    // Only the low NUM_PORTS bits of a write are kept
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            enable_con  <= '1;
            enable_stat <= '1;
            counter_con <= '0;
        end else begin
            if (wr_fire && req_addr == router_regmap_pkg::ADDR_PORT_ENABLE_CON) begin
                enable_con <= req_wdata[router_cfg_pkg::NUM_PORTS-1:0];
            end
            if (wr_fire && req_addr == router_regmap_pkg::ADDR_COUNTER_CON) begin
                counter_con <= req_wdata[router_cfg_pkg::NUM_PORTS-1:0];
            end
            // Status trails the control register by one cycle
            enable_stat <= enable_con;
        end
    end

endmodule

// File: hdl/port_cnt_snapshot.sv
/* Per-port counter slice: sample and drop edge detection, drop counter,
   snapshot registers */

module port_cnt_snapshot (
    input  logic                             core_clk_ifc,
    input  logic                             peripheral_sresetn_core,
    input  logic                             sample_req,
    input  logic                             buf_full_drop,
    input  logic [router_cfg_pkg::CNT_W-1:0] pkt_cnt,
    input  logic [router_cfg_pkg::CNT_W-1:0] byte_cnt,
    input  logic [router_cfg_pkg::CNT_W-1:0] err_cnt,
    output logic [router_cfg_pkg::CNT_W-1:0] snap_pkt,
    output logic [router_cfg_pkg::CNT_W-1:0] snap_byte,
    output logic [router_cfg_pkg::CNT_W-1:0] snap_err,
    output logic [router_cfg_pkg::CNT_W-1:0] snap_drop
);

    logic                             sample_d;
    logic                             drop_d;
    logic                             sample_rise;
    logic                             drop_rise;
    logic [router_cfg_pkg::CNT_W-1:0] drop_cnt;

    assign sample_rise = sample_req && !sample_d;
    assign drop_rise   = buf_full_drop && !drop_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_d <= 1'b0;
            drop_d   <= 1'b0;
            drop_cnt <= '0;
        end else begin
            sample_d <= sample_req;
            drop_d   <= buf_full_drop;
            // A drop edge on the sample cycle opens the new interval
            if (sample_rise) begin
                drop_cnt <= drop_rise ? router_cfg_pkg::CNT_W'(1) : '0;
            end else if (drop_rise) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    // Snapshot of live counters and the closed drop interval
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            snap_pkt  <= '0;
            snap_byte <= '0;
            snap_err  <= '0;
            snap_drop <= '0;
        end else if (sample_rise) begin
            snap_pkt  <= pkt_cnt;
            snap_byte <= byte_cnt;
            snap_err  <= err_cnt;
            snap_drop <= drop_cnt;
        end
    end

endmodule

// File: hdl/reg_read_mux.sv
/* Read path: register word selection and the registered response channel */

module reg_read_mux (
    input  logic                                                        core_clk_ifc,
    input  logic                                                        peripheral_sresetn_core,

    // Accepted access
    input  logic                                                        acc_valid,
    input  logic [router_regmap_pkg::ADDR_W-1:0]                        acc_addr,
    input  logic                                                        acc_error,

    // Register sources
    input  logic [router_cfg_pkg::NUM_PORTS-1:0]                        enable_con,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0]                        enable_stat,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0]                        counter_con,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] snap_pkt,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] snap_byte,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] snap_err,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] snap_drop,

    // Response channel
    output logic                                                        rsp_valid,
    input  logic                                                        rsp_ready,
    output logic [router_cfg_pkg::CNT_W-1:0]                            rsp_rdata,
    output logic                                                        rsp_error,
    output logic                                                        rsp_slot_free
);

    localparam int PAD_W = router_cfg_pkg::CNT_W - router_cfg_pkg::NUM_PORTS;

    logic                             in_counters;
    int                               cnt_offset;
    int                               cnt_port;
    int                               cnt_idx;
    logic [router_cfg_pkg::CNT_W-1:0] rd_word;

    // Port and slot within the snapshot area
    assign in_counters = acc_addr >= router_regmap_pkg::ADDR_COUNTERS_START &&
                         acc_addr < router_regmap_pkg::TOTAL_REGS;
    assign cnt_offset  = int'(acc_addr) - router_regmap_pkg::ADDR_COUNTERS_START;
    assign cnt_port    = cnt_offset / router_regmap_pkg::CNTRS_PER_PORT;
    assign cnt_idx     = cnt_offset % router_regmap_pkg::CNTRS_PER_PORT;

    ////////////////////////////////////////
    // Word select
    ////////////////////////////////////////

    // Unmapped addresses read as zero
    always_comb begin
        rd_word = '0;
        case (acc_addr)
            router_regmap_pkg::ADDR_VERSION_ID:       rd_word = router_regmap_pkg::VERSION_ID_VAL;
            router_regmap_pkg::ADDR_PORTS_PARAM:      rd_word = router_cfg_pkg::NUM_PORTS;
            router_regmap_pkg::ADDR_MTU_PARAM:        rd_word = router_cfg_pkg::MTU_BYTES;
            router_regmap_pkg::ADDR_PORT_ENABLE_CON:  rd_word = {{PAD_W{1'b0}}, enable_con};
            router_regmap_pkg::ADDR_PORT_ENABLE_STAT: rd_word = {{PAD_W{1'b0}}, enable_stat};
            router_regmap_pkg::ADDR_COUNTER_CON:      rd_word = {{PAD_W{1'b0}}, counter_con};
            default: begin
                if (in_counters) begin
                    case (cnt_idx)
                        router_regmap_pkg::IDX_PKT:  rd_word = snap_pkt[cnt_port];
                        router_regmap_pkg::IDX_BYTE: rd_word = snap_byte[cnt_port];
                        router_regmap_pkg::IDX_ERR:  rd_word = snap_err[cnt_port];
                        default:                     rd_word = snap_drop[cnt_port];
                    endcase
                end
            end
        endcase
    end

    ////////////////////////////////////////
    // Response register
    ////////////////////////////////////////

    assign rsp_slot_free = !rsp_valid || rsp_ready;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rsp_valid <= 1'b0;
        end else if (rsp_slot_free) begin
            rsp_valid <= acc_valid;
        end
    end

    // Held while the requester stalls
    always_ff @(posedge core_clk_ifc) begin
        if (rsp_slot_free && acc_valid) begin
            rsp_rdata <= rd_word;
            rsp_error <= acc_error;
        end
    end

endmodule

// File: hdl/p4_router_regs.sv
/* Ingress register block top: access controller, per-port snapshot slices
   and read multiplexer */

module p4_router_regs (
    input  logic                                                        core_clk_ifc,
    input  logic                                                        peripheral_sresetn_core,

    // Request channel
    input  logic                                                        req_valid,
    output logic                                                        req_ready,
    input  logic                                                        req_write,
    input  logic [router_regmap_pkg::ADDR_W-1:0]                        req_addr,
    input  logic [router_cfg_pkg::CNT_W-1:0]                            req_wdata,

    // Response channel
    output logic                                                        rsp_valid,
    input  logic                                                        rsp_ready,
    output logic [router_cfg_pkg::CNT_W-1:0]                            rsp_rdata,
    output logic                                                        rsp_error,

    // Port signals
    output logic [router_cfg_pkg::NUM_PORTS-1:0]                        port_enable,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] pkt_cnt,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] byte_cnt,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] err_cnt,
    input  logic [router_cfg_pkg::NUM_PORTS-1:0]                        buf_full_drop
);

    logic                                                        rsp_slot_free;
    logic                                                        acc_valid;
    logic [router_regmap_pkg::ADDR_W-1:0]                        acc_addr;
    logic                                                        acc_error;
    logic [router_cfg_pkg::NUM_PORTS-1:0]                        enable_stat;
    logic [router_cfg_pkg::NUM_PORTS-1:0]                        counter_con;
    logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] snap_pkt;
    logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] snap_byte;
    logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] snap_err;
    logic [router_cfg_pkg::NUM_PORTS-1:0][router_cfg_pkg::CNT_W-1:0] snap_drop;

    // port_enable is the enable control register itself
    reg_access_ctrl u_ctrl (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .req_valid               (req_valid),
        .req_ready               (req_ready),
        .req_write               (req_write),
        .req_addr                (req_addr),
        .req_wdata               (req_wdata),
        .rsp_slot_free           (rsp_slot_free),
        .acc_valid               (acc_valid),
        .acc_addr                (acc_addr),
        .acc_error               (acc_error),
        .enable_con              (port_enable),
        .enable_stat             (enable_stat),
        .counter_con             (counter_con)
    );

    // One snapshot slice per ingress port
    for (genvar p = 0; p < router_cfg_pkg::NUM_PORTS; p++) begin : g_port
        port_cnt_snapshot u_snap (
            .core_clk_ifc            (core_clk_ifc),
            .peripheral_sresetn_core (peripheral_sresetn_core),
            .sample_req              (counter_con[p]),
            .buf_full_drop           (buf_full_drop[p]),
            .pkt_cnt                 (pkt_cnt[p]),
            .byte_cnt                (byte_cnt[p]),
            .err_cnt                 (err_cnt[p]),
            .snap_pkt                (snap_pkt[p]),
            .snap_byte               (snap_byte[p]),
            .snap_err                (snap_err[p]),
            .snap_drop               (snap_drop[p])
        );
    end

    reg_read_mux u_rd_mux (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .acc_valid               (acc_valid),
        .acc_addr                (acc_addr),
        .acc_error               (acc_error),
        .enable_con              (port_enable),
        .enable_stat             (enable_stat),
        .counter_con             (counter_con),
        .snap_pkt                (snap_pkt),
        .snap_byte               (snap_byte),
        .snap_err                (snap_err),
        .snap_drop               (snap_drop),
        .rsp_valid               (rsp_valid),
        .rsp_ready               (rsp_ready),
        .rsp_rdata               (rsp_rdata),
        .rsp_error               (rsp_error),
        .rsp_slot_free           (rsp_slot_free)
    );

endmodule

// File: dv/p4_router_regs_tb.sv
/* Testbench for the ingress register block: access table checked against a
   reference model, back-pressure run and watchdog */

module p4_router_regs_tb;

    localparam int W      = router_cfg_pkg::CNT_W;
    localparam int NP     = router_cfg_pkg::NUM_PORTS;
    localparam int TOTAL  = router_regmap_pkg::TOTAL_REGS;
    localparam int CPP    = router_regmap_pkg::CNTRS_PER_PORT;
    localparam int A_CNT  = router_regmap_pkg::ADDR_COUNTERS_START;
    localparam int A_ENC  = router_regmap_pkg::ADDR_PORT_ENABLE_CON;
    localparam int A_CCON = router_regmap_pkg::ADDR_COUNTER_CON;
    localparam int BP_N   = 64;
    // Table entry kinds
    localparam int K_RD = 0, K_WR = 1, K_LIVE = 2, K_DROP = 3, K_IDLE = 4, K_PEN = 5;

    logic                                 core_clk_ifc = 1'b0;
    logic                                 peripheral_sresetn_core;
    logic                                 req_valid, req_ready, req_write;
    logic [router_regmap_pkg::ADDR_W-1:0] req_addr;
    logic [W-1:0]                         req_wdata, rsp_rdata;
    logic                                 rsp_valid, rsp_ready, rsp_error;
    logic [NP-1:0]                        port_enable, buf_full_drop;
    logic [NP-1:0][W-1:0]                 pkt_cnt, byte_cnt, err_cnt;

    // Access table, one entry per index
    int           tab_kind[$];
    int           tab_addr[$];
    logic [W-1:0] tab_wdata[$];
    logic [W-1:0] tab_exp[$];
    logic         tab_err[$];

    // Reference model state
    logic [NP-1:0] m_en_con = '1;
    logic [NP-1:0] m_cnt_con = '0;
    logic [W-1:0]  m_live[NP][3];
    logic [W-1:0]  m_snap[NP][CPP];
    int            m_drop[NP];
    int            n_checks = 0;
    int            n_errors = 0;
    bit            table_built = 1'b0;

    p4_router_regs UUT (.*);

    always #4 core_clk_ifc = ~core_clk_ifc;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Distinct live value per port and counter (0 pkt, 1 byte, 2 err)
    function automatic logic [W-1:0] live_word(input logic [W-1:0] base, input int p, input int c);
        return base + (p << 16) + (c << 8);
    endfunction

    function automatic logic [W-1:0] model_read(input int addr, output logic err);
        int off;
        err = addr >= TOTAL;
        off = addr - A_CNT;
        case (addr)
            router_regmap_pkg::ADDR_VERSION_ID:       return router_regmap_pkg::VERSION_ID_VAL;
            router_regmap_pkg::ADDR_PORTS_PARAM:      return NP;
            router_regmap_pkg::ADDR_MTU_PARAM:        return router_cfg_pkg::MTU_BYTES;
            router_regmap_pkg::ADDR_PORT_ENABLE_CON:  return m_en_con;
            // Status has long settled by the time of any read
            router_regmap_pkg::ADDR_PORT_ENABLE_STAT: return m_en_con;
            router_regmap_pkg::ADDR_COUNTER_CON:      return m_cnt_con;
            default:                                  return err ? '0 : m_snap[off / CPP][off % CPP];
        endcase
    endfunction

    task automatic add_entry(input int kind, input int addr, input logic [W-1:0] wdata,
                             input logic [W-1:0] exp, input logic err);
        tab_kind.push_back(kind);
        tab_addr.push_back(addr);
        tab_wdata.push_back(wdata);
        tab_exp.push_back(exp);
        tab_err.push_back(err);
    endtask

    task automatic add_read(input int addr);
        logic [W-1:0] d;
        logic         e;
        d = model_read(addr, e);
        add_entry(K_RD, addr, '0, d, e);
    endtask

    task automatic add_write(input int addr, input logic [W-1:0] data);
        logic [NP-1:0] v;
        v = data[NP-1:0];
        add_entry(K_WR, addr, data, '0, addr >= TOTAL);
        if (addr == A_ENC)
            m_en_con = v;
        if (addr == A_CCON) begin
            // A rising bit closes the interval of that port
            for (int p = 0; p < NP; p++) begin
                if (v[p] && !m_cnt_con[p]) begin
                    for (int c = 0; c < 3; c++)
                        m_snap[p][c] = m_live[p][c];
                    m_snap[p][router_regmap_pkg::IDX_DROP] = m_drop[p];
                    m_drop[p] = 0;
                end
            end
            m_cnt_con = v;
        end
    endtask

    // Non-access steps: live values, drop pulses, idle cycles, port_enable check
    task automatic add_op(input int kind, input logic [W-1:0] arg);
        add_entry(kind, 0, arg, m_en_con, 1'b0);
        for (int p = 0; p < NP; p++) begin
            if (kind == K_DROP)
                m_drop[p] += p;
            for (int c = 0; c < 3; c++) begin
                if (kind == K_LIVE)
                    m_live[p][c] = live_word(arg, p, c);
            end
        end
    endtask

    task automatic build_table();
        for (int p = 0; p < NP; p++) begin
            m_drop[p] = 0;
            for (int c = 0; c < CPP; c++)
                m_snap[p][c] = '0;
            for (int c = 0; c < 3; c++)
                m_live[p][c] = '0;
        end
        // Reset values of the whole map
        for (int a = 0; a < TOTAL; a++)
            add_read(a);
        // Unmapped and read-only addresses
        add_read(TOTAL);
        add_read(TOTAL + 9);
        add_read(255);
        add_write(TOTAL, 32'hdead_beef);
        add_write(255, 32'h0000_0001);
        add_write(router_regmap_pkg::ADDR_VERSION_ID, 32'h1234_5678);
        add_write(router_regmap_pkg::ADDR_MTU_PARAM, 32'h0000_0040);
        add_write(router_regmap_pkg::ADDR_PORT_ENABLE_STAT, 32'h0);
        add_read(router_regmap_pkg::ADDR_VERSION_ID);
        add_read(router_regmap_pkg::ADDR_MTU_PARAM);
        add_read(router_regmap_pkg::ADDR_PORT_ENABLE_STAT);
        // Port enable
        add_write(A_ENC, 32'hffff_fff5);
        add_op(K_PEN, '0);
        add_read(A_ENC);
        add_read(router_regmap_pkg::ADDR_PORT_ENABLE_STAT);
        add_write(A_ENC, 32'h0000_000a);
        add_op(K_PEN, '0);
        add_read(router_regmap_pkg::ADDR_PORT_ENABLE_STAT);
        // Two snapshot rounds on alternate ports
        for (int r = 0; r < 2; r++) begin
            add_op(K_LIVE, r ? 32'h2000_0000 : 32'h1000_0000);
            add_write(A_CCON, '0);
            add_write(A_CCON, r ? 32'h0000_000a : 32'h0000_0005);
            add_op(K_IDLE, '0);
            add_read(A_CCON);
            for (int a = A_CNT; a < TOTAL; a++)
                add_read(a);
        end
        // Drop counts, then an interval without drops
        for (int r = 0; r < 2; r++) begin
            add_write(A_CCON, '0);
            if (r == 0)
                add_op(K_DROP, '0);
            add_write(A_CCON, 32'h0000_000f);
            add_op(K_IDLE, '0);
            for (int p = 0; p < NP; p++)
                add_read(A_CNT + p * CPP + router_regmap_pkg::IDX_DROP);
        end
    endtask

    ////////////////////////////////////////
    // Bus driving and checks
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic do_access(input logic wr, input int addr, input logic [W-1:0] wdata,
                             output logic [W-1:0] rdata, output logic err);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(posedge core_clk_ifc);
        while (!req_ready)
            @(posedge core_clk_ifc);
        req_valid <= 1'b0;
        @(posedge core_clk_ifc);
        while (!(rsp_valid && rsp_ready))
            @(posedge core_clk_ifc);
        rdata = rsp_rdata;
        err   = rsp_error;
    endtask

    task automatic run_table();
        logic [W-1:0] d;
        logic         e;
        for (int i = 0; i < tab_kind.size(); i++) begin
            case (tab_kind[i])
                K_LIVE: begin
                    for (int p = 0; p < NP; p++) begin
                        pkt_cnt[p]  <= live_word(tab_wdata[i], p, 0);
                        byte_cnt[p] <= live_word(tab_wdata[i], p, 1);
                        err_cnt[p]  <= live_word(tab_wdata[i], p, 2);
                    end
                    @(posedge core_clk_ifc);
                end
                K_DROP: begin
                    // Port k sees k pulses, one cycle high and one low
                    for (int j = 0; j < NP; j++) begin
                        for (int p = 0; p < NP; p++)
                            buf_full_drop[p] <= p > j;
                        @(posedge core_clk_ifc);
                        buf_full_drop <= '0;
                        @(posedge core_clk_ifc);
                    end
                end
                K_IDLE: repeat (2) @(posedge core_clk_ifc);
                K_PEN:  check_value("port_enable", port_enable, tab_exp[i]);
                default: begin
                    do_access(tab_kind[i] == K_WR, tab_addr[i], tab_wdata[i], d, e);
                    check_value($sformatf("rsp_rdata at 0x%0h", tab_addr[i]), d, tab_exp[i]);
                    check_value($sformatf("rsp_error at 0x%0h", tab_addr[i]), e, tab_err[i]);
                end
            endcase
        end
    endtask

    // Back-to-back random reads against a randomly stalling rsp_ready
    task automatic back_pressure();
        int exp_q[$];
        fork
            begin : sender
                int a;
                for (int i = 0; i < BP_N; i++) begin
                    a = $urandom_range(TOTAL + 1, 0);
                    exp_q.push_back(a);
                    req_valid <= 1'b1;
                    req_write <= 1'b0;
                    req_addr  <= a;
                    @(posedge core_clk_ifc);
                    while (!req_ready)
                        @(posedge core_clk_ifc);
                end
                req_valid <= 1'b0;
            end
            begin : receiver
                int           n;
                int           a;
                logic [W-1:0] d;
                logic         e;
                n = 0;
                while (n < BP_N) begin
                    rsp_ready <= $urandom_range(1, 0);
                    @(posedge core_clk_ifc);
                    // A waiting response blocks new requests
                    if (rsp_valid && !rsp_ready)
                        check_value("req_ready", req_ready, 1'b0);
                    if (rsp_valid && rsp_ready) begin
                        a = exp_q.pop_front();
                        d = model_read(a, e);
                        check_value($sformatf("rsp_rdata at 0x%0h", a), rsp_rdata, d);
                        check_value($sformatf("rsp_error at 0x%0h", a), rsp_error, e);
                        n++;
                    end
                end
                rsp_ready <= 1'b1;
            end
        join
        // No response beyond one per request
        @(posedge core_clk_ifc);
        check_value("rsp_valid", rsp_valid, '0);
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hf0a922e2));
        peripheral_sresetn_core <= 1'b0;
        req_valid     <= 1'b0;
        req_write     <= 1'b0;
        req_addr      <= '0;
        req_wdata     <= '0;
        rsp_ready     <= 1'b1;
        buf_full_drop <= '0;
        pkt_cnt       <= '0;
        byte_cnt      <= '0;
        err_cnt       <= '0;
        build_table();
        table_built = 1'b1;
        repeat (4) @(posedge core_clk_ifc);
        peripheral_sresetn_core <= 1'b1;
        // Idle state left by reset
        check_value("rsp_valid", rsp_valid, '0);
        check_value("req_ready", req_ready, 1'b1);
        check_value("port_enable", port_enable, {NP{1'b1}});
        run_table();
        back_pressure();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        wait (table_built);
        repeat ((tab_kind.size() + BP_N) * 50) @(posedge core_clk_ifc);
        $display("Timeout: the DUT stopped answering before all accesses were done");
        $display("Test failed");
        $finish;
    end

endmodule

// File: p4_router_regs.f
hdl/router_cfg_pkg.sv
hdl/router_regmap_pkg.sv
hdl/reg_access_ctrl.sv
hdl/port_cnt_snapshot.sv
hdl/reg_read_mux.sv
hdl/p4_router_regs.sv
dv/p4_router_regs_tb.sv
